//--- logic/acc_defs.svh
// ====================================================================
// Shared widths and sizes for the accelerator control slice
// Include wherever a width or the FIFO depth is needed
// Include guard keeps repeated inclusion harmless
// ====================================================================
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

// Host configuration word
`define ACC_CFG_W 16

// Operand widths, both signed
`define ACC_ACT_W 8
`define ACC_WGT_W 8

// Lane accumulator, covers 64 x 128 x 128 with sign
`define ACC_SUM_W 24

// Saturated result toward the global buffer
`define ACC_RES_W 16

// Beat counter, counts up to 64
`define ACC_LEN_W 7

// Config FIFO address bits, 8 words = four queued jobs
`define ACC_FIFO_AW 3

`endif

//--- logic/acc_pkg.sv
// ====================================================================
// Common types for the accelerator control slice
// Width typedefs carry meaning at the module ports
// Controller state encoding lives here as well
// ====================================================================
`include "acc_defs.svh"

package acc_pkg;

    // Raw configuration word as pushed by the host
    typedef logic [`ACC_CFG_W-1:0] cfg_word_t;

    // Signed operands of one lane
    typedef logic signed [`ACC_ACT_W-1:0] act_t;
    typedef logic signed [`ACC_WGT_W-1:0] wgt_t;

    // Lane accumulator value
    typedef logic signed [`ACC_SUM_W-1:0] sum_t;

    // Clamped result word
    typedef logic signed [`ACC_RES_W-1:0] res_t;

    // Job length and beat count, 1 to 64
    typedef logic [`ACC_LEN_W-1:0] len_t;

    // Job sequencing states
    typedef enum logic [2:0] {
        IDLE,
        CFG_LEN,
        CFG_WGT,
        CMP,
        DRAIN,
        WAITGBF
    } ccu_state_t;

endpackage

//--- logic/lane_if.sv
// ====================================================================
// Control bundle from the job controller to one PE lane
// One instance per lane, ctrl side drives and pe side receives
// ====================================================================
`timescale 1ns/1ps

interface lane_if;
    import acc_pkg::*;

    // Zero the accumulator on this edge
    logic clr;

    // Accumulate act * wgt on this edge
    logic en;

    // Operand pair for the lane
    act_t act;
    wgt_t wgt;

    // Controller side
    modport ctrl (
        output clr,
        output en,
        output act,
        output wgt
    );

    // Processing element side
    modport pe (
        input clr,
        input en,
        input act,
        input wgt
    );

endinterface

//--- logic/cfg_fifo.sv
// ====================================================================
// Synchronous FIFO for host configuration words
// Pop data is the head word, valid whenever empty is low
// Push and pop may happen in the same cycle
// ====================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module cfg_fifo #(
    parameter int addr_width = `ACC_FIFO_AW
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  acc_pkg::cfg_word_t push_data,
    input  logic               pop,
    output acc_pkg::cfg_word_t pop_data,
    output logic               empty,
    output logic               full
);
    import acc_pkg::*;

    localparam int depth = 1 << addr_width;

    // Word storage
    cfg_word_t mem [depth];

    // Extra MSB tells full from empty
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;

    // Qualified transfers
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Same index, wrap bits differ when full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // Head word shown combinationally
    assign pop_data = mem[rd_ptr[addr_width-1:0]];

    // ================================================================
    // Write port
    // ================================================================
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[addr_width-1:0]] <= push_data;
        end
    end

    // ================================================================
    // Pointers
    // ================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + (addr_width + 1)'(1);
            end
            // Head advances after the pop edge
            if (do_pop) begin
                rd_ptr <= rd_ptr + (addr_width + 1)'(1);
            end
        end
    end

endmodule

//--- logic/ccu_ctrl.sv
// ====================================================================
// Central job controller
// Pops two config words per job, feeds L activation beats to the
// two lanes, fires the combiner and waits for the result handshake
// ====================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module ccu_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  acc_pkg::cfg_word_t        fifo_data,
    input  logic                      fifo_empty,
    output logic                      fifo_pop,
    input  logic [2*`ACC_ACT_W-1:0]   act_data,
    input  logic                      act_val,
    output logic                      act_rdy,
    lane_if.ctrl                      lane0,
    lane_if.ctrl                      lane1,
    output logic                      fire,
    input  logic                      res_taken,
    output logic                      busy,
    output logic                      done
);
    import acc_pkg::*;

    ccu_state_t state;
    ccu_state_t state_nxt;

    // Job length and accepted beats
    len_t job_len;
    len_t beat_cnt;

    // Lane weights from word 1
    wgt_t w0_q;
    wgt_t w1_q;

    logic load_len;
    logic load_wgt;
    logic beat_acc;
    logic last_beat;

    // ================================================================
    // Handshake decode
    // ================================================================
    // One word per config state, only when present
    assign load_len = (state == CFG_LEN) && !fifo_empty;
    assign load_wgt = (state == CFG_WGT) && !fifo_empty;
    assign fifo_pop = load_len || load_wgt;

    // Activations only accepted while computing
    assign act_rdy   = (state == CMP);
    assign beat_acc  = act_rdy && act_val;
    assign last_beat = beat_acc && ((beat_cnt + len_t'(1)) == job_len);

    assign fire = (state == DRAIN);
    assign busy = (state != IDLE);

    // ================================================================
    // FSM
    // ================================================================
    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:    if (start)     state_nxt = CFG_LEN;
            CFG_LEN: if (load_len)  state_nxt = CFG_WGT;
            CFG_WGT: if (load_wgt)  state_nxt = CMP;
            CMP:     if (last_beat) state_nxt = DRAIN;
            // Single cycle for the combiner to sample
            DRAIN:                  state_nxt = WAITGBF;
            WAITGBF: if (res_taken) state_nxt = IDLE;
            default:                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            job_len  <= '0;
            beat_cnt <= '0;
            done     <= 1'b0;
        end else begin
            state <= state_nxt;
            // Low 6 bits plus one
            if (load_len) begin
                job_len <= {1'b0, fifo_data[`ACC_LEN_W-2:0]} + len_t'(1);
            end
            // Fresh count for each job
            if (load_wgt) begin
                beat_cnt <= '0;
            end else if (beat_acc) begin
                beat_cnt <= beat_cnt + len_t'(1);
            end
            // Pulse together with the return to IDLE
            done <= (state == WAITGBF) && res_taken;
        end
    end

    // Weights held for the whole job
    always_ff @(posedge clk) begin
        if (load_wgt) begin
            w0_q <= fifo_data[`ACC_CFG_W-1 -: `ACC_WGT_W];
            w1_q <= fifo_data[`ACC_WGT_W-1:0];
        end
    end

    // ================================================================
    // Lane drive
    // ================================================================
    // Clear lands on the same edge the weights load
    assign lane0.clr = load_wgt;
    assign lane1.clr = load_wgt;
    assign lane0.en  = beat_acc;
    assign lane1.en  = beat_acc;

    // a0 high byte, a1 low byte
    assign lane0.act = act_data[2*`ACC_ACT_W-1 -: `ACC_ACT_W];
    assign lane1.act = act_data[`ACC_ACT_W-1:0];
    assign lane0.wgt = w0_q;
    assign lane1.wgt = w1_q;

endmodule

//--- logic/pe_lane.sv
// ====================================================================
// Processing element for one activation lane
// Signed 8x8 multiply into a 24-bit accumulator
// Sum is valid one cycle after each accepted beat
// ====================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module pe_lane (
    input  logic          clk,
    input  logic          rst_n,
    lane_if.pe            lane,
    output acc_pkg::sum_t sum
);
    import acc_pkg::*;

    // Full precision product
    logic signed [`ACC_ACT_W+`ACC_WGT_W-1:0] prod;

    // Running sum
    sum_t acc;

    // Both operands signed, so a signed multiply
    assign prod = lane.act * lane.wgt;

    // ================================================================
    // Accumulator
    // ================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (lane.clr) begin
            // New job starts from zero
            acc <= '0;
        end else if (lane.en) begin
            // Product sign extended to 24 bits
            acc <= acc + sum_t'(prod);
        end
    end

    assign sum = acc;

endmodule

//--- logic/lane_combine.sv
// ====================================================================
// Result combiner for the two lanes
// Adds both lane sums, clamps to signed 16 bits and holds the word
// with res_val until the global buffer takes it
// ====================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module lane_combine (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          fire,
    input  acc_pkg::sum_t sum0,
    input  acc_pkg::sum_t sum1,
    input  logic          res_rdy,
    output acc_pkg::res_t res_data,
    output logic          res_val
);
    import acc_pkg::*;

    // One guard bit over the lane sum
    localparam int tot_w = `ACC_SUM_W + 1;

    // Result range limits
    localparam logic signed [tot_w-1:0] res_max = 2 ** (`ACC_RES_W - 1) - 1;
    localparam logic signed [tot_w-1:0] res_min = -(2 ** (`ACC_RES_W - 1));

    logic signed [tot_w-1:0] total;
    res_t                    clamped;

    // Sign extend both sums before the add
    assign total = $signed({sum0[`ACC_SUM_W-1], sum0}) +
                   $signed({sum1[`ACC_SUM_W-1], sum1});

    // ================================================================
    // Saturation
    // ================================================================
    always_comb begin
        if (total > res_max) begin
            clamped = res_t'(res_max);
        end else if (total < res_min) begin
            clamped = res_t'(res_min);
        end else begin
            clamped = res_t'(total);
        end
    end

    // Held until the handshake edge
    always_ff @(posedge clk) begin
        if (fire) begin
            res_data <= clamped;
        end
    end

    // Valid rises after fire, drops on the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_val <= 1'b0;
        end else if (fire) begin
            res_val <= 1'b1;
        end else if (res_rdy) begin
            res_val <= 1'b0;
        end
    end

endmodule

//--- logic/acc_core.sv
// ====================================================================
// Top level of the accelerator control slice
// Host config words go through the FIFO to the controller
// Activations feed two PE lanes whose sums the combiner
// clamps and offers to the global buffer
// ====================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module acc_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  acc_pkg::cfg_word_t      cfg_data,
    input  logic                    cfg_val,
    output logic                    cfg_rdy,
    input  logic [2*`ACC_ACT_W-1:0] act_data,
    input  logic                    act_val,
    output logic                    act_rdy,
    output acc_pkg::res_t           res_data,
    output logic                    res_val,
    input  logic                    res_rdy,
    output logic                    busy,
    output logic                    done
);
    import acc_pkg::*;

    // FIFO side
    cfg_word_t fifo_data;
    logic      fifo_push;
    logic      fifo_pop;
    logic      fifo_empty;
    logic      fifo_full;

    // Lane sums and result control
    sum_t sum0;
    sum_t sum1;
    logic fire;
    logic res_taken;

    // Controller to lane bundles
    lane_if lane0_if ();
    lane_if lane1_if ();

    // Ready while a slot is free
    assign cfg_rdy   = !fifo_full;
    assign fifo_push = cfg_val && cfg_rdy;

    // Result handshake seen by the controller
    assign res_taken = res_val && res_rdy;

    // ================================================================
    // Instances
    // ================================================================
    cfg_fifo #(
        .addr_width (`ACC_FIFO_AW)
    ) u_cfg_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_data (cfg_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    ccu_ctrl u_ccu_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .act_data   (act_data),
        .act_val    (act_val),
        .act_rdy    (act_rdy),
        .lane0      (lane0_if.ctrl),
        .lane1      (lane1_if.ctrl),
        .fire       (fire),
        .res_taken  (res_taken),
        .busy       (busy),
        .done       (done)
    );

    // a0 * w0 lane
    pe_lane lane0 (
        .clk   (clk),
        .rst_n (rst_n),
        .lane  (lane0_if.pe),
        .sum   (sum0)
    );

    // a1 * w1 lane
    pe_lane lane1 (
        .clk   (clk),
        .rst_n (rst_n),
        .lane  (lane1_if.pe),
        .sum   (sum1)
    );

    lane_combine u_lane_combine (
        .clk      (clk),
        .rst_n    (rst_n),
        .fire     (fire),
        .sum0     (sum0),
        .sum1     (sum1),
        .res_rdy  (res_rdy),
        .res_data (res_data),
        .res_val  (res_val)
    );

endmodule

//--- verification/acc_core_checker.sv
// ======================================================================
// Reference model and protocol watcher for acc_core
// Samples every port on the rising clock edge, rebuilds each job from
// the config and activation transfers and compares the result word
// Error and result counts are outputs for the testbench top
// ======================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module acc_core_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  acc_pkg::cfg_word_t      cfg_data,
    input  logic                    cfg_val,
    input  logic                    cfg_rdy,
    input  logic [2*`ACC_ACT_W-1:0] act_data,
    input  logic                    act_val,
    input  logic                    act_rdy,
    input  acc_pkg::res_t           res_data,
    input  logic                    res_val,
    input  logic                    res_rdy,
    input  logic                    busy,
    input  logic                    done,
    output int                      err_cnt,
    output int                      res_cnt,
    output int                      done_cnt
);
    import acc_pkg::*;

    localparam int fifo_depth = 1 << `ACC_FIFO_AW;

    // Accepted config words, two leave per finished job
    cfg_word_t               cfg_q [$];
    // Activation beats of the running job
    logic [2*`ACC_ACT_W-1:0] beat_q [$];

    int   cyc;
    int   last_beat_cyc;
    logic reset_seen;
    logic took_prev;
    logic val_prev;
    logic rdy_prev;
    logic start_prev;
    logic busy_prev;
    res_t data_prev;

    initial begin
        err_cnt       = 0;
        res_cnt       = 0;
        done_cnt      = 0;
        cyc           = 0;
        last_beat_cyc = -100;
        reset_seen    = 1'b0;
        took_prev     = 1'b0;
        val_prev      = 1'b0;
        rdy_prev      = 1'b0;
        start_prev    = 1'b0;
        busy_prev     = 1'b0;
        data_prev     = '0;
    end

    task automatic mismatch(input string name, input int exp, input int got);
        $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        err_cnt++;
    endtask

    task automatic protocol_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // ==================================================================
    // Reference model for one finished job
    // ==================================================================
    task automatic check_result();
        cfg_word_t len_word;
        cfg_word_t wgt_word;
        int        len;
        int        s0;
        int        s1;
        int        total;
        byte       a0;
        byte       a1;
        byte       w0;
        byte       w1;
        if (cfg_q.size() < 2) begin
            protocol_error("result offered without two configuration words");
        end else begin
            len_word = cfg_q.pop_front();
            wgt_word = cfg_q.pop_front();
            len      = int'(len_word[5:0]) + 1;
            w0       = wgt_word[15:8];
            w1       = wgt_word[7:0];
            s0       = 0;
            s1       = 0;
            if (beat_q.size() != len) begin
                mismatch("accepted beats", len, beat_q.size());
            end
            foreach (beat_q[i]) begin
                a0 = beat_q[i][15:8];
                a1 = beat_q[i][7:0];
                s0 = s0 + int'(a0) * int'(w0);
                s1 = s1 + int'(a1) * int'(w1);
            end
            // Clamp to the signed 16-bit range
            total = s0 + s1;
            if (total > 32767) total = 32767;
            if (total < -32768) total = -32768;
            if (int'(res_data) != total) begin
                mismatch("res_data", total, int'(res_data));
            end
        end
        beat_q.delete();
        res_cnt++;
    endtask

    // ==================================================================
    // Per-edge watching
    // ==================================================================
    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            // First edge out of reset
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (act_rdy || res_val || busy || done || !cfg_rdy) begin
                    protocol_error("port values after reset are wrong");
                end
            end
            if (act_rdy && !busy) protocol_error("act_rdy high outside a job");
            if (res_val && act_rdy) protocol_error("act_rdy high while result pending");
            if (start_prev && !busy_prev && !busy) protocol_error("busy did not follow start");
            // done one cycle after the result handshake
            if (done !== took_prev) mismatch("done", took_prev, done);
            if (done) done_cnt++;
            // While idle every finished job has left the FIFO
            if (!busy && (cfg_rdy !== (cfg_q.size() < fifo_depth))) begin
                mismatch("cfg_rdy", cfg_q.size() < fifo_depth, cfg_rdy);
            end
            // Result held under back-pressure
            if (val_prev && !rdy_prev) begin
                if (!res_val) protocol_error("res_val dropped without handshake");
                if (!busy) protocol_error("controller left job with result pending");
                if (res_data !== data_prev) mismatch("res_data hold", data_prev, res_data);
            end
            if (res_val && !val_prev && (cyc != last_beat_cyc + 2)) begin
                mismatch("res_val rise cycle", last_beat_cyc + 2, cyc);
            end
            if (cfg_val && cfg_rdy) cfg_q.push_back(cfg_data);
            if (act_val && act_rdy) begin
                beat_q.push_back(act_data);
                last_beat_cyc = cyc;
            end
            if (res_val && res_rdy) check_result();
            took_prev  = res_val && res_rdy;
            val_prev   = res_val;
            rdy_prev   = res_rdy;
            start_prev = start;
            busy_prev  = busy;
            data_prev  = res_data;
        end
    end

endmodule

//--- verification/acc_core_tb.sv
// ======================================================================
// Testbench top for acc_core
// Drives queued, saturating and random jobs from an LFSR, with gaps on
// the activation stream and stalls on the result port
// The checker compares every result, this top checks the job totals
// ======================================================================
`timescale 1ns/1ps
`include "acc_defs.svh"

module acc_core_tb;
    import acc_pkg::*;

    // Queued, saturating and random jobs
    localparam int job_count = 4 + 2 + 40;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    cfg_word_t               cfg_data;
    logic                    cfg_val;
    logic                    cfg_rdy;
    logic [2*`ACC_ACT_W-1:0] act_data;
    logic                    act_val;
    logic                    act_rdy;
    res_t                    res_data;
    logic                    res_val;
    logic                    res_rdy;
    logic                    busy;
    logic                    done;
    int                      err_cnt;
    int                      res_cnt;
    int                      done_cnt;
    logic [31:0]             lfsr;
    int                      len_q [$];

    acc_core uut (.*);

    acc_core_checker u_checker (.*);

    always #5 clk = ~clk;

    // ==================================================================
    // Random bits, x^32 + x^22 + x^2 + x + 1
    // ==================================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // One word, held until cfg_rdy is seen at an edge
    task automatic push_word(input cfg_word_t w);
        cfg_data = w;
        cfg_val  = 1'b1;
        do begin
            @(posedge clk);
        end while (!cfg_rdy);
        #1 cfg_val = 1'b0;
    endtask

    // Length word with junk in the unused bits, then the weights
    task automatic push_job_cfg(input int len, input cfg_word_t wgt);
        logic [31:0] r;
        rand_bits(10, r);
        push_word({r[9:0], 6'(len - 1)});
        push_word(wgt);
    endtask

    task automatic run_job(input int len, input logic rnd, input logic [15:0] fix);
        logic [31:0] r;
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        for (int i = 0; i < len; i++) begin
            act_data = fix;
            if (rnd) begin
                // Roughly one idle cycle in four
                rand_bits(2, r);
                while (r[1:0] == 2'b00) begin
                    @(posedge clk);
                    #1 rand_bits(2, r);
                end
                rand_bits(16, r);
                act_data = r[15:0];
            end
            act_val = 1'b1;
            do begin
                @(posedge clk);
            end while (!act_rdy);
            #1 act_val = 1'b0;
        end
        while (!res_val) begin
            @(posedge clk);
            #1;
        end
        // Global buffer stalls 0 to 7 cycles
        // A start raised during the stall must not begin a job
        rand_bits(3, r);
        start = 1'b1;
        repeat (r[2:0]) @(posedge clk);
        #1 start = 1'b0;
        res_rdy = 1'b1;
        @(posedge clk);
        #1 res_rdy = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          len;
        int          total_err;
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg_data = '0;
        cfg_val  = 1'b0;
        act_data = '0;
        act_val  = 1'b0;
        res_rdy  = 1'b0;
        lfsr     = 32'd70318;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        // Four jobs fill the FIFO before the first start
        for (int j = 0; j < 4; j++) begin
            rand_bits(6, r);
            len = int'(r[5:0]) + 1;
            len_q.push_back(len);
            rand_bits(16, r);
            push_job_cfg(len, r[15:0]);
        end
        repeat (4) @(posedge clk);
        #1;
        while (len_q.size() > 0) run_job(len_q.pop_front(), 1'b1, '0);
        // Saturation at both ends
        push_job_cfg(64, 16'h7F7F);
        run_job(64, 1'b0, 16'h7F7F);
        push_job_cfg(64, 16'h7F7F);
        run_job(64, 1'b0, 16'h8080);
        for (int j = 0; j < 40; j++) begin
            rand_bits(6, r);
            len = int'(r[5:0]) + 1;
            rand_bits(16, r);
            push_job_cfg(len, r[15:0]);
            run_job(len, 1'b1, '0);
        end
        repeat (5) @(posedge clk);
        total_err = err_cnt;
        if (res_cnt != job_count || done_cnt != job_count) begin
            $display("ERROR: %0d jobs run but %0d results and %0d done pulses seen",
                     job_count, res_cnt, done_cnt);
            total_err++;
        end
        $display("Summary: %0d jobs, %0d results, %0d done pulses, %0d errors",
                 job_count, res_cnt, done_cnt, total_err);
        if (total_err == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Worst job is about 104 cycles of 10 ns
    initial begin
        #(job_count * 104 * 10 + 5000);
        $display("ERROR: timeout, the DUT stopped making progress");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- acc_core.f
+incdir+logic
logic/acc_pkg.sv
logic/lane_if.sv
logic/cfg_fifo.sv
logic/ccu_ctrl.sv
logic/pe_lane.sv
logic/lane_combine.sv
logic/acc_core.sv
verification/acc_core_checker.sv
verification/acc_core_tb.sv
